// File: fetch_stage.f
hdl/fetch_pkg.sv
hdl/fetch_out_if.sv
hdl/fetch_target_mux.sv
hdl/fetch_controller.sv
hdl/fetch_buffer.sv
hdl/if_id_register.sv
hdl/fetch_stage.sv
verif/tb_instr_memory.sv
verif/tb_fetch_stage.sv

// File: hdl/fetch_buffer.sv
/*
 * Prefetch response buffer
 *   FIFO of instruction words and bus error flags
 *   Head PC register, advanced per consumed entry
 *   Flush and PC load on redirect, free slot count
 */
module fetch_buffer (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  pc_set_i,       // Redirect flushes the FIFO
  input  logic [fetch_pkg::XLEN-1:0]            target_i,       // New head PC
  input  logic                                  resp_keep_i,    // Write strobe
  input  logic [fetch_pkg::XLEN-1:0]            instr_rdata_i,
  input  logic                                  instr_err_i,
  output logic [fetch_pkg::FETCH_CNT_WIDTH-1:0] free_slots_o,
  output logic [fetch_pkg::XLEN-1:0]            pc_if_o,        // PC of the head entry
  fetch_out_if.buf_src                          out
);
  import fetch_pkg::*;

  logic [XLEN-1:0]            rdata_q [FETCH_BUF_DEPTH];  // Instruction words
  logic                       err_q   [FETCH_BUF_DEPTH];  // Bus error per entry
  logic [FETCH_PTR_WIDTH-1:0] wr_ptr_q;
  logic [FETCH_PTR_WIDTH-1:0] rd_ptr_q;
  logic [FETCH_CNT_WIDTH-1:0] count_q;                    // Filled entries
  logic [XLEN-1:0]            pc_q;
  logic                       pop;

  ///////////////////////////////////////////////////////////////////////
  // Head entry
  ///////////////////////////////////////////////////////////////////////

  assign pop       = out.valid && out.ready;
  assign out.valid = (count_q != '0);
  assign out.pc    = pc_q;
  assign out.rdata = rdata_q[rd_ptr_q];
  assign out.err   = err_q[rd_ptr_q];

  assign pc_if_o      = pc_q;
  assign free_slots_o = FETCH_BUF_DEPTH - count_q;

  // Storage, valid entries are tracked by the pointers below
  always_ff @(posedge clk) begin
    if (resp_keep_i) begin
      rdata_q[wr_ptr_q] <= instr_rdata_i;
      err_q[wr_ptr_q]   <= instr_err_i;
    end
  end

  ///////////////////////////////////////////////////////////////////////
  // Pointers, fill level and head PC
  ///////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      pc_q     <= '0;
    end else if (pc_set_i) begin
      wr_ptr_q <= '0;                                  // Flush beats write and read
      rd_ptr_q <= '0;
      count_q  <= '0;
      pc_q     <= target_i;
    end else begin
      if (resp_keep_i) begin
        wr_ptr_q <= wr_ptr_q + FETCH_PTR_WIDTH'(1);
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + FETCH_PTR_WIDTH'(1);
        pc_q     <= pc_q + XLEN'(4);                   // Word aligned stream
      end
      count_q <= count_q + FETCH_CNT_WIDTH'(resp_keep_i) - FETCH_CNT_WIDTH'(pop);
    end
  end

endmodule

// File: hdl/fetch_controller.sv
/*
 * Prefetch request controller
 *   Fetch address register and bus request generation
 *   Outstanding and discard counters, stale request tracking
 *   Response keep strobe and busy flag
 */
module fetch_controller (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  pc_set_i,        // Redirect strobe
  input  logic [fetch_pkg::XLEN-1:0]            target_i,        // Redirect target
  input  logic [fetch_pkg::FETCH_CNT_WIDTH-1:0] free_slots_i,    // Room left in the buffer
  input  logic                                  instr_gnt_i,
  input  logic                                  instr_rvalid_i,
  output logic                                  instr_req_o,
  output logic [fetch_pkg::XLEN-1:0]            instr_addr_o,
  output logic                                  resp_keep_o,     // Response goes to buffer
  output logic                                  busy_o
);
  import fetch_pkg::*;

  typedef enum logic {
    FETCH_IDLE,  // No target yet after reset
    FETCH_RUN    // Sequential prefetching
  } fetch_state_e;

  fetch_state_e               state_q;
  logic [XLEN-1:0]            addr_q;        // Next address of the current stream
  logic [XLEN-1:0]            stale_addr_q;  // Held address of a pre-redirect request
  logic                       stale_q;       // Bus still owes a grant for an old request
  logic [FETCH_CNT_WIDTH-1:0] out_cnt_q;     // Outstanding, response kept
  logic [FETCH_CNT_WIDTH-1:0] disc_cnt_q;    // Outstanding, response dropped
  logic [FETCH_CNT_WIDTH-1:0] total_cnt;
  logic                       issue_ok;
  logic                       gnt;
  logic                       disc_gnt;
  logic                       kept_gnt;
  logic                       resp_drop;

  ///////////////////////////////////////////////////////////////////////
  // Request side
  ///////////////////////////////////////////////////////////////////////

  assign total_cnt = out_cnt_q + disc_cnt_q;

  // Every response must find a free buffer slot
  assign issue_ok = (state_q == FETCH_RUN)
                 && (total_cnt < FETCH_MAX_OUTSTANDING)
                 && (out_cnt_q < free_slots_i);

  assign instr_req_o  = stale_q || issue_ok;                // Stale request held until granted
  assign instr_addr_o = stale_q ? stale_addr_q : addr_q;

  assign gnt      = instr_req_o && instr_gnt_i;
  assign disc_gnt = gnt && (stale_q || pc_set_i);           // Belongs to an old stream
  assign kept_gnt = gnt && !disc_gnt;

  // Responses come in order, so discards are always the oldest ones
  assign resp_drop   = instr_rvalid_i && (disc_cnt_q != '0);
  assign resp_keep_o = instr_rvalid_i && !resp_drop;

  assign busy_o = (total_cnt != '0);

  ///////////////////////////////////////////////////////////////////////
  // State and counters
  ///////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q      <= FETCH_IDLE;
      addr_q       <= '0;
      stale_addr_q <= '0;
      stale_q      <= 1'b0;
      out_cnt_q    <= '0;
      disc_cnt_q   <= '0;
    end else if (pc_set_i) begin
      state_q      <= FETCH_RUN;
      addr_q       <= target_i;
      // An ungranted request keeps its address and is dropped later
      stale_q      <= instr_req_o && !instr_gnt_i;
      stale_addr_q <= instr_addr_o;
      out_cnt_q    <= '0;
      // Everything in flight now belongs to the old stream
      disc_cnt_q   <= total_cnt + FETCH_CNT_WIDTH'(disc_gnt)
                    - FETCH_CNT_WIDTH'(instr_rvalid_i);
    end else begin
      if (kept_gnt) begin
        addr_q <= addr_q + XLEN'(4);                        // Next word
      end
      if (stale_q && instr_gnt_i) begin
        stale_q <= 1'b0;
      end
      out_cnt_q  <= out_cnt_q + FETCH_CNT_WIDTH'(kept_gnt) - FETCH_CNT_WIDTH'(resp_keep_o);
      disc_cnt_q <= disc_cnt_q + FETCH_CNT_WIDTH'(disc_gnt) - FETCH_CNT_WIDTH'(resp_drop);
    end
  end

endmodule

// File: hdl/fetch_out_if.sv
/*
 * Fetch output interface
 *   Head entry of the response buffer towards the IF/ID register
 *   valid/ready handshake, entry consumed when both are high
 */
interface fetch_out_if;
  import fetch_pkg::*;

  logic            valid;  // Head entry present
  logic [XLEN-1:0] pc;     // PC of the head entry
  logic [XLEN-1:0] rdata;  // Instruction word
  logic            err;    // Bus error on this fetch
  logic            ready;  // Pipeline register takes the head

  // Response buffer side
  modport buf_src (
    output valid, pc, rdata, err,
    input  ready
  );

  // Pipeline register side
  modport pipe_dst (
    input  valid, pc, rdata, err,
    output ready
  );

endinterface

// File: hdl/fetch_pkg.sv
/*
 * Shared definitions of the instruction fetch stage
 *   Address, instruction and trap vector widths
 *   NMI vector index
 *   Prefetch counter, outstanding limit and response buffer sizes
 *   Redirect source encoding
 */
package fetch_pkg;

  ///////////////////////////////////////////////////////////////////////
  // Widths
  ///////////////////////////////////////////////////////////////////////

  localparam int XLEN             = 32;  // Address and instruction width
  localparam int MTVEC_BASE_WIDTH = 25;  // mtvec base gives addr[31:7]
  localparam int IRQ_ID_WIDTH     = 5;   // Vectored interrupt id

  // NMI takes a fixed slot of the vector table
  localparam logic [IRQ_ID_WIDTH-1:0] NMI_MTVEC_INDEX = 5'd15;

  ///////////////////////////////////////////////////////////////////////
  // Prefetch sizes
  ///////////////////////////////////////////////////////////////////////

  // Counters for outstanding, discarded and free entries
  localparam int FETCH_CNT_WIDTH = 2;

  // Granted but unanswered bus transactions
  localparam logic [FETCH_CNT_WIDTH-1:0] FETCH_MAX_OUTSTANDING = 2'd2;

  // Response buffer entries
  localparam logic [FETCH_CNT_WIDTH-1:0] FETCH_BUF_DEPTH = 2'd2;
  localparam int FETCH_PTR_WIDTH = $clog2(FETCH_BUF_DEPTH);  // Read/write pointer width

  ///////////////////////////////////////////////////////////////////////
  // Redirect sources
  ///////////////////////////////////////////////////////////////////////

  typedef enum logic [3:0] {
    PC_BOOT     = 4'd0,  // Boot address
    PC_JUMP     = 4'd1,  // Jump target from ID
    PC_BRANCH   = 4'd2,  // Taken branch from EX
    PC_MRET     = 4'd3,  // Return to mepc
    PC_DRET     = 4'd4,  // Return from debug mode to dpc
    PC_TRAP_EXC = 4'd5,  // Exceptions share the mtvec base
    PC_TRAP_IRQ = 4'd6,  // Vectored interrupt
    PC_TRAP_NMI = 4'd7,  // Non-maskable interrupt
    PC_TRAP_DBD = 4'd8,  // Debug halt entry
    PC_TRAP_DBE = 4'd9   // Exception inside debug mode
  } pc_mux_e;

endpackage

// File: hdl/fetch_stage.sv
/*
 * Instruction fetch stage, top level
 *   Redirect target mux, prefetch controller, response buffer
 *   IF/ID pipeline register and the fetch output interface
 */
module fetch_stage (
  input  logic                                   clk,
  input  logic                                   rst_n,

  // Redirect from the controller
  input  logic                                   pc_set_i,
  input  fetch_pkg::pc_mux_e                     pc_mux_i,
  input  logic [fetch_pkg::XLEN-1:0]             boot_addr_i,
  input  logic [fetch_pkg::XLEN-1:0]             jump_target_i,
  input  logic [fetch_pkg::XLEN-1:0]             branch_target_i,
  input  logic [fetch_pkg::XLEN-1:0]             mepc_i,
  input  logic [fetch_pkg::XLEN-1:0]             dpc_i,
  input  logic [fetch_pkg::XLEN-1:0]             dm_halt_addr_i,
  input  logic [fetch_pkg::XLEN-1:0]             dm_exception_addr_i,
  input  logic [fetch_pkg::MTVEC_BASE_WIDTH-1:0] mtvec_addr_i,
  input  logic [fetch_pkg::IRQ_ID_WIDTH-1:0]     irq_id_i,
  output logic                                   mtvec_init_o,

  // Instruction bus
  output logic                                   instr_req_o,
  output logic [fetch_pkg::XLEN-1:0]             instr_addr_o,
  input  logic                                   instr_gnt_i,
  input  logic                                   instr_rvalid_i,
  input  logic [fetch_pkg::XLEN-1:0]             instr_rdata_i,
  input  logic                                   instr_err_i,

  // Pipeline control and ID side
  input  logic                                   id_ready_i,
  input  logic                                   halt_if_i,
  input  logic                                   kill_if_i,
  output logic                                   id_valid_o,
  output logic [fetch_pkg::XLEN-1:0]             id_pc_o,
  output logic [fetch_pkg::XLEN-1:0]             id_instr_o,
  output logic                                   id_instr_err_o,

  // Status
  output logic                                   if_busy_o,
  output logic [fetch_pkg::XLEN-1:0]             pc_if_o
);
  import fetch_pkg::*;

  logic [XLEN-1:0]            target;      // Redirect target, valid with pc_set_i
  logic                       resp_keep;   // Response for the live stream
  logic [FETCH_CNT_WIDTH-1:0] free_slots;

  fetch_out_if fetch_out ();               // Buffer head to pipeline register

  fetch_target_mux u_target_mux (
    .pc_mux_i            (pc_mux_i),
    .pc_set_i            (pc_set_i),
    .boot_addr_i         (boot_addr_i),
    .jump_target_i       (jump_target_i),
    .branch_target_i     (branch_target_i),
    .mepc_i              (mepc_i),
    .dpc_i               (dpc_i),
    .dm_halt_addr_i      (dm_halt_addr_i),
    .dm_exception_addr_i (dm_exception_addr_i),
    .mtvec_addr_i        (mtvec_addr_i),
    .irq_id_i            (irq_id_i),
    .target_o            (target),
    .mtvec_init_o        (mtvec_init_o)
  );

  fetch_controller u_controller (
    .clk            (clk),
    .rst_n          (rst_n),
    .pc_set_i       (pc_set_i),
    .target_i       (target),
    .free_slots_i   (free_slots),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .resp_keep_o    (resp_keep),
    .busy_o         (if_busy_o)
  );

  fetch_buffer u_buffer (
    .clk           (clk),
    .rst_n         (rst_n),
    .pc_set_i      (pc_set_i),
    .target_i      (target),
    .resp_keep_i   (resp_keep),
    .instr_rdata_i (instr_rdata_i),
    .instr_err_i   (instr_err_i),
    .free_slots_o  (free_slots),
    .pc_if_o       (pc_if_o),
    .out           (fetch_out)
  );

  if_id_register u_if_id (
    .clk            (clk),
    .rst_n          (rst_n),
    .id_ready_i     (id_ready_i),
    .halt_if_i      (halt_if_i),
    .kill_if_i      (kill_if_i),
    .in             (fetch_out),
    .id_valid_o     (id_valid_o),
    .id_pc_o        (id_pc_o),
    .id_instr_o     (id_instr_o),
    .id_instr_err_o (id_instr_err_o)
  );

endmodule

// File: hdl/fetch_target_mux.sv
/*
 * Redirect target selection
 *   Picks the next fetch address from the redirect source
 *   Builds trap and vectored interrupt addresses from mtvec
 *   Raises the mtvec init pulse on a boot redirect
 */
module fetch_target_mux (
  input  fetch_pkg::pc_mux_e                      pc_mux_i,             // Redirect source
  input  logic                                    pc_set_i,             // Redirect strobe
  input  logic [fetch_pkg::XLEN-1:0]              boot_addr_i,
  input  logic [fetch_pkg::XLEN-1:0]              jump_target_i,
  input  logic [fetch_pkg::XLEN-1:0]              branch_target_i,
  input  logic [fetch_pkg::XLEN-1:0]              mepc_i,               // Trap return address
  input  logic [fetch_pkg::XLEN-1:0]              dpc_i,                // Debug return address
  input  logic [fetch_pkg::XLEN-1:0]              dm_halt_addr_i,
  input  logic [fetch_pkg::XLEN-1:0]              dm_exception_addr_i,
  input  logic [fetch_pkg::MTVEC_BASE_WIDTH-1:0]  mtvec_addr_i,         // mtvec base, addr[31:7]
  input  logic [fetch_pkg::IRQ_ID_WIDTH-1:0]      irq_id_i,             // Interrupt vector index
  output logic [fetch_pkg::XLEN-1:0]              target_o,             // Word aligned target
  output logic                                    mtvec_init_o          // CSR file loads mtvec
);
  import fetch_pkg::*;

  // Zero fill below the mtvec base for the common exception entry
  localparam int EXC_PAD_WIDTH = XLEN - MTVEC_BASE_WIDTH;

  ///////////////////////////////////////////////////////////////////////
  // Target selection
  ///////////////////////////////////////////////////////////////////////

  always_comb begin
    target_o = {boot_addr_i[XLEN-1:2], 2'b00};  // Unused encodings fall back to boot

    case (pc_mux_i)
      PC_BOOT:     target_o = {boot_addr_i[XLEN-1:2], 2'b00};
      PC_JUMP:     target_o = {jump_target_i[XLEN-1:2], 2'b00};
      PC_BRANCH:   target_o = {branch_target_i[XLEN-1:2], 2'b00};
      PC_MRET:     target_o = {mepc_i[XLEN-1:2], 2'b00};
      PC_DRET:     target_o = {dpc_i[XLEN-1:2], 2'b00};
      PC_TRAP_EXC: target_o = {mtvec_addr_i, {EXC_PAD_WIDTH{1'b0}}};  // All exceptions on base
      PC_TRAP_IRQ: target_o = {mtvec_addr_i, irq_id_i, 2'b00};        // One word per id
      PC_TRAP_NMI: target_o = {mtvec_addr_i, NMI_MTVEC_INDEX, 2'b00};
      PC_TRAP_DBD: target_o = {dm_halt_addr_i[XLEN-1:2], 2'b00};
      PC_TRAP_DBE: target_o = {dm_exception_addr_i[XLEN-1:2], 2'b00};
      default: ;
    endcase
  end

  // mtvec gets its reset value only when the core boots
  assign mtvec_init_o = pc_set_i && (pc_mux_i == PC_BOOT);

endmodule

// File: hdl/if_id_register.sv
/*
 * IF/ID pipeline register
 *   Stage ready from halt, kill and ID back-pressure
 *   Captures PC, instruction word and bus error on a transfer
 */
module if_id_register (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       id_ready_i,      // ID can accept
  input  logic                       halt_if_i,       // Controller holds IF
  input  logic                       kill_if_i,       // Controller drops the IF entry
  fetch_out_if.pipe_dst              in,
  output logic                       id_valid_o,
  output logic [fetch_pkg::XLEN-1:0] id_pc_o,
  output logic [fetch_pkg::XLEN-1:0] id_instr_o,
  output logic                       id_instr_err_o
);

  logic transfer;

  // Kill drains the head without handing it to ID
  assign in.ready = kill_if_i || (id_ready_i && !halt_if_i);

  assign transfer = in.valid && id_ready_i && !halt_if_i && !kill_if_i;

  ///////////////////////////////////////////////////////////////////////
  // Pipeline register
  ///////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      id_valid_o <= 1'b0;
    end else if (transfer) begin
      id_valid_o <= 1'b1;
    end else if (id_ready_i || kill_if_i) begin
      id_valid_o <= 1'b0;                              // Bubble into ID
    end
  end

  // Payload, holds while ID stalls
  always_ff @(posedge clk) begin
    if (transfer) begin
      id_pc_o        <= in.pc;
      id_instr_o     <= in.rdata;
      id_instr_err_o <= in.err;
    end
  end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Build the fetch stage testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module tb_fetch_stage -f fetch_stage.f -Mdir obj_dir \
  && ./obj_dir/Vtb_fetch_stage | tee /dev/stderr | grep -qx "RESULT: PASS" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

// File: verif/tb_fetch_stage.sv
/*
 * Table-driven testbench of the fetch stage
 *   Clock, reset, bus model and redirect rows applied in a loop
 *   Reference targets and sequential instruction stream checks
 *   Halt, kill, ID stall and bus error cases
 *   mtvec init pulse and busy monitors, cycle limit and final report
 */
module tb_fetch_stage;
  import fetch_pkg::*;

  localparam int NUM_ROWS    = 11;
  localparam int HALT_CYCLES = 6;   // Halt rows hold IF this long after the redirect

  typedef struct {
    pc_mux_e                     src;
    logic [XLEN-1:0]             op;     // Address operand of the selected source
    logic [MTVEC_BASE_WIDTH-1:0] mtvec;
    logic [IRQ_ID_WIDTH-1:0]     irq;
    int                          n;      // Instructions to collect
    logic [7:0]                  stall;  // id_ready pattern, bit per cycle
    logic                        halt;
    logic                        kill;
  } row_t;

  logic                        clk = 1'b0;
  logic                        rst_n;
  logic                        pc_set_i;
  pc_mux_e                     pc_mux_i;
  logic [XLEN-1:0]             boot_addr_i, jump_target_i, branch_target_i;
  logic [XLEN-1:0]             mepc_i, dpc_i, dm_halt_addr_i, dm_exception_addr_i;
  logic [MTVEC_BASE_WIDTH-1:0] mtvec_addr_i;
  logic [IRQ_ID_WIDTH-1:0]     irq_id_i;
  logic                        mtvec_init_o;
  logic                        instr_req_o, instr_gnt_i, instr_rvalid_i, instr_err_i;
  logic [XLEN-1:0]             instr_addr_o, instr_rdata_i;
  logic                        id_ready_i, halt_if_i, kill_if_i;
  logic                        id_valid_o, id_instr_err_o, if_busy_o;
  logic [XLEN-1:0]             id_pc_o, id_instr_o, pc_if_o;

  row_t rows [NUM_ROWS];
  int   row_errors;
  int   rows_failed;
  int   pulse_errors;
  int   busy_errors;
  int   bus_pending;                // Granted bus transactions still unanswered
  logic init_expected;              // Boot redirect driven in this cycle
  int   cycle_count;
  int   cycle_limit = 100;

  always #20 clk = ~clk;

  fetch_stage DUT (.*);

  tb_instr_memory u_mem (
    .clk      (clk),
    .rst_n    (rst_n),
    .req_i    (instr_req_o),
    .addr_i   (instr_addr_o),
    .gnt_o    (instr_gnt_i),
    .rvalid_o (instr_rvalid_i),
    .rdata_o  (instr_rdata_i),
    .err_o    (instr_err_i)
  );

  ///////////////////////////////////////////////////////////////////////
  // Stimulus table and reference
  ///////////////////////////////////////////////////////////////////////

  task automatic load_table();
    //          src          op             mtvec          irq    n  stall         halt  kill
    rows[0]  = '{PC_BOOT,     32'h0000_1003, 25'h0,         5'd0,  6, 8'hFF,        1'b0, 1'b0};
    rows[1]  = '{PC_JUMP,     32'h0000_2106, 25'h0,         5'd0,  5, 8'b1011_0101, 1'b0, 1'b0};
    rows[2]  = '{PC_BRANCH,   32'h0000_3201, 25'h0,         5'd0,  5, 8'hFF,        1'b1, 1'b0};
    rows[3]  = '{PC_MRET,     32'h0000_4402, 25'h0,         5'd0,  4, 8'b0110_1101, 1'b0, 1'b1};
    rows[4]  = '{PC_DRET,     32'h0000_5503, 25'h0,         5'd0,  4, 8'hFF,        1'b0, 1'b0};
    rows[5]  = '{PC_TRAP_EXC, 32'h0000_0000, 25'h000_0123,  5'd0,  4, 8'b1101_1011, 1'b0, 1'b0};
    rows[6]  = '{PC_TRAP_IRQ, 32'h0000_0000, 25'h000_0124,  5'd11, 3, 8'hFF,        1'b0, 1'b0};
    rows[7]  = '{PC_TRAP_NMI, 32'h0000_0000, 25'h000_0125,  5'd3,  3, 8'hFF,        1'b0, 1'b0};
    rows[8]  = '{PC_TRAP_DBD, 32'h0000_6607, 25'h0,         5'd0,  4, 8'b0111_0111, 1'b1, 1'b0};
    rows[9]  = '{PC_TRAP_DBE, 32'h0000_7709, 25'h0,         5'd0,  4, 8'hFF,        1'b0, 1'b1};
    rows[10] = '{PC_JUMP,     32'h0001_EFF5, 25'h0,         5'd0,  6, 8'b1010_1111, 1'b0, 1'b0};
  endtask

  // Word aligned target from the redirect rules
  function automatic logic [XLEN-1:0] ref_target(input row_t r);
    case (r.src)
      PC_TRAP_EXC: return {r.mtvec, 7'b0};
      PC_TRAP_IRQ: return {r.mtvec, r.irq, 2'b00};
      PC_TRAP_NMI: return {r.mtvec, 5'd15, 2'b00};  // Fixed NMI slot
      default:     return {r.op[XLEN-1:2], 2'b00};
    endcase
  endfunction

  // Unselected sources carry distinct values so a wrong pick shows up
  task automatic drive_redirect(input row_t r);
    boot_addr_i         = 32'hB000_0104;
    jump_target_i       = 32'hB100_0208;
    branch_target_i     = 32'hB200_030C;
    mepc_i              = 32'hB300_0410;
    dpc_i               = 32'hB400_0514;
    dm_halt_addr_i      = 32'hB500_0618;
    dm_exception_addr_i = 32'hB600_071C;
    mtvec_addr_i        = r.mtvec;
    irq_id_i            = r.irq;
    case (r.src)
      PC_BOOT:     boot_addr_i         = r.op;
      PC_JUMP:     jump_target_i       = r.op;
      PC_BRANCH:   branch_target_i     = r.op;
      PC_MRET:     mepc_i              = r.op;
      PC_DRET:     dpc_i               = r.op;
      PC_TRAP_DBD: dm_halt_addr_i      = r.op;
      PC_TRAP_DBE: dm_exception_addr_i = r.op;
      default: ;
    endcase
    pc_mux_i      = r.src;
    pc_set_i      = 1'b1;
    init_expected = (r.src == PC_BOOT);                // Only a boot redirect loads mtvec
    id_ready_i    = 1'b1;                              // Drain what ID holds
    halt_if_i     = !r.kill;                           // Old head stays out of ID
    kill_if_i     = r.kill;
  endtask

  // One instruction taken by ID, compared with the memory rules
  task automatic check_instr(input logic [XLEN-1:0] pc);
    logic [XLEN-1:0] word;
    logic            err;
    word = pc ^ 32'h5A5A_0000;
    err  = &pc[15:12];
    assert (id_pc_o == pc) else begin
      $display("[ERROR] id_pc_o: got %h, expected %h", id_pc_o, pc);
      row_errors++;
    end
    assert (id_instr_o == word) else begin
      $display("[ERROR] id_instr_o: got %h, expected %h", id_instr_o, word);
      row_errors++;
    end
    assert (id_instr_err_o == err) else begin
      $display("[ERROR] id_instr_err_o: got %h, expected %h", id_instr_err_o, err);
      row_errors++;
    end
    // Buffer head is the word after the one in ID
    assert (pc_if_o == pc + 32'd4) else begin
      $display("[ERROR] pc_if_o: got %h, expected %h", pc_if_o, pc + 32'd4);
      row_errors++;
    end
  endtask

  ///////////////////////////////////////////////////////////////////////
  // Row execution
  ///////////////////////////////////////////////////////////////////////

  task automatic run_row(input int idx);
    row_t            r;
    pc_mux_e         src;
    logic [XLEN-1:0] exp_pc;
    logic [XLEN-1:0] prev_pc;
    logic            halt_prev;
    logic            prev_valid;
    logic            prev_ready;
    int              c;
    int              got;
    r          = rows[idx];
    src        = r.src;
    exp_pc     = ref_target(r);
    row_errors = 0;
    c          = 0;
    got        = 0;
    halt_prev  = 1'b1;                                 // Redirect cycle halts or kills
    prev_valid = 1'b0;
    prev_ready = 1'b1;
    prev_pc    = '0;
    @(negedge clk);
    drive_redirect(r);
    while (got < r.n) begin
      @(negedge clk);
      if (halt_prev) begin
        assert (!id_valid_o) else begin
          $display("[ERROR] id_valid_o: got %h, expected 0", id_valid_o);
          row_errors++;
        end
      end
      if (c == 0) begin                                // Head PC loaded by the redirect
        assert (pc_if_o == exp_pc) else begin
          $display("[ERROR] pc_if_o: got %h, expected %h", pc_if_o, exp_pc);
          row_errors++;
        end
      end
      if (prev_valid && !prev_ready) begin             // ID stalled, entry must hold
        assert (id_valid_o && id_pc_o == prev_pc) else begin
          $display("[ERROR] id_pc_o under stall: got %h, expected %h", id_pc_o, prev_pc);
          row_errors++;
        end
      end
      pc_set_i      = 1'b0;
      init_expected = 1'b0;
      kill_if_i     = 1'b0;
      halt_if_i     = r.halt && (c < HALT_CYCLES);
      id_ready_i    = r.stall[3'(c)];
      if (id_valid_o && id_ready_i) begin              // Taken at the next edge
        check_instr(exp_pc);
        exp_pc += 32'd4;
        got++;
      end
      halt_prev  = halt_if_i;
      prev_valid = id_valid_o;
      prev_ready = id_ready_i;
      prev_pc    = id_pc_o;
      c++;
    end
    if (row_errors != 0) begin
      rows_failed++;
    end
    $display("Row %0d %s: %0d instructions from %h, %0d errors",
             idx, src.name(), r.n, ref_target(r), row_errors);
  endtask

  // mtvec init only in the cycle of a boot redirect
  always @(posedge clk) begin
    if (rst_n) begin
      assert (mtvec_init_o == init_expected) else begin
        $display("[ERROR] mtvec_init_o: got %h, expected %h", mtvec_init_o, init_expected);
        pulse_errors++;
      end
    end
  end

  // Bus transactions seen at the edge, discarded ones included
  always @(posedge clk) begin
    if (!rst_n) begin
      bus_pending = 0;
    end else begin
      bus_pending = bus_pending + int'(instr_req_o && instr_gnt_i) - int'(instr_rvalid_i);
    end
  end

  // Busy while the bus owes any response
  always @(negedge clk) begin
    assert (if_busy_o == (bus_pending != 0)) else begin
      $display("[ERROR] if_busy_o: got %h, expected %h", if_busy_o, bus_pending != 0);
      busy_errors++;
    end
  end

  // Cycle limit
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > cycle_limit) begin
      $display("Timeout: the instruction stream did not complete in %0d cycles", cycle_count);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  initial begin
    int total;
    rst_n         = 1'b0;
    pc_set_i      = 1'b0;
    init_expected = 1'b0;
    pc_mux_i      = PC_JUMP;
    id_ready_i    = 1'b0;
    halt_if_i     = 1'b0;
    kill_if_i     = 1'b0;
    {boot_addr_i, jump_target_i, branch_target_i, mepc_i} = '0;
    {dpc_i, dm_halt_addr_i, dm_exception_addr_i} = '0;
    mtvec_addr_i = '0;
    irq_id_i     = '0;
    load_table();
    total = 0;
    foreach (rows[i]) total += rows[i].n;
    cycle_limit = 20 * total + 100;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    for (int i = 0; i < NUM_ROWS; i++) begin
      run_row(i);
    end
    $display("Rows passed: %0d, failed: %0d, pulse errors: %0d, busy errors: %0d",
             NUM_ROWS - rows_failed, rows_failed, pulse_errors, busy_errors);
    if (rows_failed == 0 && pulse_errors == 0 && busy_errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: verif/tb_instr_memory.sv
/*
 * Instruction bus model for the fetch stage testbench
 *   Random grant, one in two cycles on average
 *   In-order responses after 1 or 2 cycles
 *   Data and error flag derived from the word address
 */
module tb_instr_memory (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        req_i,
  input  logic [31:0] addr_i,
  output logic        gnt_o,
  output logic        rvalid_o,
  output logic [31:0] rdata_o,
  output logic        err_o
);

  integer      seed = 25;       // Shared by grant and delay draws
  int          cyc;             // Bus cycle count
  int          rnd_gnt;
  int          rnd_dly;
  logic        gnt_coin;
  logic [31:0] pend_addr [$];   // Granted, not yet answered
  int          pend_due  [$];   // Cycle from which the response may go out

  assign gnt_o = req_i && gnt_coin;

  initial begin
    gnt_coin = 1'b0;
    rvalid_o = 1'b0;
    rdata_o  = '0;
    err_o    = 1'b0;
  end

  // Handshakes as the DUT sees them at the edge
  always @(posedge clk) begin
    if (!rst_n) begin
      cyc = 0;
      pend_addr.delete();
      pend_due.delete();
    end else begin
      cyc++;
      if (rvalid_o) begin
        void'(pend_addr.pop_front());                  // Answer taken at this edge
        void'(pend_due.pop_front());
      end
      if (req_i && gnt_o) begin
        rnd_dly = $random(seed);
        pend_addr.push_back(addr_i);
        pend_due.push_back(cyc + (rnd_dly & 1));       // 1 or 2 cycles later
      end
    end
  end

  ///////////////////////////////////////////////////////////////////////
  // Outputs change on the falling edge
  ///////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    rnd_gnt  = $random(seed);
    gnt_coin = rst_n && rnd_gnt[0];
    rvalid_o = 1'b0;
    rdata_o  = '0;
    err_o    = 1'b0;
    if (rst_n && pend_due.size() != 0) begin
      if (pend_due[0] <= cyc) begin                    // Oldest first, so order holds
        rvalid_o = 1'b1;
        rdata_o  = pend_addr[0] ^ 32'h5A5A_0000;
        err_o    = &pend_addr[0][15:12];               // Error window at 0x?F???
      end
    end
  end

endmodule
